// ==== bench/tb_zx128_glue.sv ====
module tb_zx128_glue
  import zx128_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 650000;
  localparam int RAND_TX = 1500;

  logic clk14m = 1'b0;
  logic RESET_n;
  logic [ADDR_W-1:0] cpu_addr_i;
  logic [DATA_W-1:0] cpu_data_i, rom_data_i, sram_data_i, tape_data_i;
  logic cpu_mreq_n_i, cpu_iorq_n_i, cpu_rd_n_i, cpu_wr_n_i;
  logic [KB_ROWS*KB_COLS-1:0] kb_rows_i;
  logic ear_i, tape_valid_i;
  logic [DATA_W-1:0] cpu_data_o, sram_data_o;
  logic [ROM_AW-1:0] rom_addr_o;
  logic [SRAM_AW-1:0] sram_addr_o;
  logic [2:0] border_o;
  logic sram_we_o, mic_o, ear_o, tape_hreq_o, tape_ready_o, int_o;

  ////////////////////////////////////////
  // model state
  ////////////////////////////////////////
  logic [7:0] sram_mem [logic [SRAM_AW-1:0]];
  logic [7:0] fifo_q [$];
  logic [5:0] page_q;
  logic [2:0] border_q;
  logic mic_q, ear_q, hreq_q;
  int int_cnt;
  int cycles = 0;
  int tape_rate;
  bit src_valid, took;
  logic [7:0] src_data;
  string test_name;
  // transaction in flight
  bit cur_mem, cur_io, cur_rd, cur_wr;
  logic [15:0] cur_addr;
  logic [7:0] cur_data;
  logic [KB_ROWS*KB_COLS-1:0] cur_kb;
  logic cur_ear;
  logic [ROM_AW-1:0] exp_rom_addr;
  logic [SRAM_AW-1:0] exp_sram_addr;

  always #20 clk14m = ~clk14m;

  zx128_glue dut0 (
    .clk14m(clk14m), .RESET_n(RESET_n), .cpu_addr_i(cpu_addr_i), .cpu_data_i(cpu_data_i),
    .cpu_mreq_n_i(cpu_mreq_n_i), .cpu_iorq_n_i(cpu_iorq_n_i), .cpu_rd_n_i(cpu_rd_n_i),
    .cpu_wr_n_i(cpu_wr_n_i), .rom_data_i(rom_data_i), .sram_data_i(sram_data_i),
    .kb_rows_i(kb_rows_i), .ear_i(ear_i), .tape_data_i(tape_data_i),
    .tape_valid_i(tape_valid_i), .cpu_data_o(cpu_data_o), .rom_addr_o(rom_addr_o),
    .sram_addr_o(sram_addr_o), .sram_data_o(sram_data_o), .sram_we_o(sram_we_o),
    .border_o(border_o), .mic_o(mic_o), .ear_o(ear_o), .tape_hreq_o(tape_hreq_o),
    .tape_ready_o(tape_ready_o), .int_o(int_o)
  );

  always @(posedge clk14m) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [7:0] rom_byte(input logic [ROM_AW-1:0] a);
    return a[7:0] ^ {1'b0, a[14:8]} ^ 8'h3c;
  endfunction

  // unwritten sram locations read a pattern of the full address
  function automatic logic [7:0] sram_byte(input logic [SRAM_AW-1:0] a);
    if (sram_mem.exists(a)) return sram_mem[a];
    return a[7:0] ^ a[15:8] ^ {5'b00000, a[18:16]} ^ 8'ha5;
  endfunction

  // a key column reads 0 if pressed in any selected half-row
  function automatic logic [7:0] kb_value(input logic [7:0] sel,
                                          input logic [KB_ROWS*KB_COLS-1:0] rows,
                                          input logic ear);
    logic [KB_COLS-1:0] keys;
    for (int c = 0; c < KB_COLS; c++) begin
      keys[c] = 1'b1;
      for (int r = 0; r < KB_ROWS; r++) begin
        if (!sel[r] && !rows[r*KB_COLS+c]) keys[c] = 1'b0;
      end
    end
    return {1'b1, ear, 1'b1, keys};
  endfunction

  function automatic logic [7:0] expected_read();
    bit io_rd;
    io_rd = cur_io && cur_rd;
    if (io_rd && cur_addr == PORT_HL_DATA) return (fifo_q.size() == 0) ? 8'hff : fifo_q[0];
    if (io_rd && cur_addr == PORT_HL_STATUS) begin
      return {6'b000000, fifo_q.size() == FIFO_DEPTH, fifo_q.size() == 0};
    end
    if (cur_mem && cur_rd) begin
      return (cur_addr[15:14] == 2'b00) ? rom_byte(exp_rom_addr) : sram_byte(exp_sram_addr);
    end
    if (io_rd && cur_addr[7:0] == PORT_FE_LO) return kb_value(cur_addr[15:8], cur_kb, cur_ear);
    if (io_rd && cur_addr == PORT_7FFD) return {2'b00, page_q};
    return 8'hff;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("error [%s] %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////////////////////////
  // bus cycle, drive then check
  ////////////////////////////////////////
  task automatic drive_cycle(input bit mem, input bit io, input bit rd, input bit wr,
                             input logic [15:0] addr, input logic [7:0] data);
    bank_t bank;
    cur_mem = mem;
    cur_io = io;
    cur_rd = rd;
    cur_wr = wr;
    cur_addr = addr;
    cur_data = data;
    cur_kb = {8'($urandom), 32'($urandom)};
    cur_ear = 1'($urandom);
    // tape source keeps its byte until it is taken
    if (!src_valid || took) begin
      src_valid = ($urandom % 100) < tape_rate;
      src_data = 8'($urandom);
    end
    case (addr[15:14])
      2'b01: bank = BANK_AT_4000;
      2'b10: bank = BANK_AT_8000;
      default: bank = {1'b0, page_q[2:0]};
    endcase
    exp_rom_addr = {page_q[4], addr[13:0]};
    exp_sram_addr = {1'b0, bank, addr[13:0]};
    cpu_addr_i <= addr;
    cpu_data_i <= data;
    cpu_mreq_n_i <= !mem;
    cpu_iorq_n_i <= !io;
    cpu_rd_n_i <= !rd;
    cpu_wr_n_i <= !wr;
    kb_rows_i <= cur_kb;
    ear_i <= cur_ear;
    rom_data_i <= rom_byte(exp_rom_addr);
    sram_data_i <= sram_byte(exp_sram_addr);
    tape_valid_i <= src_valid;
    tape_data_i <= src_data;
  endtask

  task automatic check_cycle();
    bit full;
    bit exp_we;
    bit pop;
    @(negedge clk14m);
    full = (fifo_q.size() == FIFO_DEPTH);
    exp_we = cur_mem && cur_wr && (cur_addr[15:14] != 2'b00);
    check_value("read data", expected_read(), cpu_data_o);
    if (cur_mem && cur_addr[15:14] != 2'b00) check_value("sram addr", exp_sram_addr, sram_addr_o);
    if (cur_mem && cur_rd && cur_addr[15:14] == 2'b00) begin
      check_value("rom addr", exp_rom_addr, rom_addr_o);
    end
    check_value("sram we", exp_we, sram_we_o);
    if (exp_we) check_value("sram write data", cur_data, sram_data_o);
    check_value("border", border_q, border_o);
    check_value("mic", mic_q, mic_o);
    check_value("ear out", ear_q, ear_o);
    check_value("tape hreq", hreq_q, tape_hreq_o);
    check_value("tape ready", !full, tape_ready_o);
    check_value("int", (int_cnt >= 1) && (int_cnt <= INT_ON), int_o);
    // effects at the closing edge
    if (exp_we) sram_mem[exp_sram_addr] = cur_data;
    if (cur_io && cur_wr && !cur_addr[0]) begin
      border_q = cur_data[2:0];
      mic_q = cur_data[3];
      ear_q = cur_data[4];
    end
    if (cur_io && cur_wr && cur_addr == PORT_7FFD && !page_q[5]) page_q = cur_data[5:0];
    if (cur_io && cur_wr && cur_addr == PORT_HL_STATUS) hreq_q = cur_data[0];
    pop = cur_io && cur_rd && (cur_addr == PORT_HL_DATA) && (fifo_q.size() != 0);
    took = src_valid && !full;
    if (pop) void'(fifo_q.pop_front());
    if (took) fifo_q.push_back(src_data);
    int_cnt = (int_cnt == INT_PERIOD - 1) ? 0 : int_cnt + 1;
  endtask

  task automatic bus_cycle(input bit mem, input bit rd, input logic [15:0] addr,
                           input logic [7:0] data);
    @(posedge clk14m);
    drive_cycle(mem, !mem, rd, !rd, addr, data);
    check_cycle();
  endtask

  task automatic idle_cycle();
    @(posedge clk14m);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 16'($urandom), 8'($urandom));
    check_cycle();
  endtask

  task automatic apply_reset();
    @(posedge clk14m);
    RESET_n <= 1'b0;
    cpu_mreq_n_i <= 1'b1;
    cpu_iorq_n_i <= 1'b1;
    cpu_rd_n_i <= 1'b1;
    cpu_wr_n_i <= 1'b1;
    tape_valid_i <= 1'b0;
    repeat (2) @(posedge clk14m);
    RESET_n <= 1'b1;
    page_q = '0;
    border_q = '0;
    mic_q = 1'b0;
    ear_q = 1'b0;
    hreq_q = 1'b0;
    fifo_q.delete();
    int_cnt = 0;
    src_valid = 1'b0;
    took = 1'b0;
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
    check_cycle();
  endtask

  // addresses lean toward the ports and the 16k boundaries
  task automatic random_transaction(input bit allow_lock);
    int kind;
    bit mem;
    bit rd;
    logic [15:0] a;
    logic [15:0] base;
    logic [7:0] d;
    kind = $urandom % 10;
    rd = 1'($urandom);
    d = 8'($urandom);
    mem = (kind < 4);
    base = {2'($urandom), 14'h0000};
    case (kind)
      0, 1: a = 16'($urandom);
      2, 3: a = base + 16'($urandom % 8) - 16'd4;
      4: a = {8'($urandom), PORT_FE_LO};
      5: begin
        a = PORT_7FFD;
        if (!allow_lock || ($urandom % 8) != 0) d[5] = 1'b0;
      end
      6: begin
        a = PORT_HL_DATA;
        rd = 1'b1;
      end
      7: a = PORT_HL_STATUS;
      default: a = 16'($urandom);
    endcase
    bus_cycle(mem, rd, a, d);
    repeat ($urandom % 3) idle_cycle();
  endtask

  task automatic fill_and_drain();
    tape_rate = 100;
    repeat (FIFO_DEPTH + 32) idle_cycle();
    check_value("fifo level", FIFO_DEPTH, fifo_q.size());
    bus_cycle(1'b0, 1'b1, PORT_HL_STATUS, 8'h00);
    tape_rate = 0;
    while (fifo_q.size() != 0) bus_cycle(1'b0, 1'b1, PORT_HL_DATA, 8'h00);
    bus_cycle(1'b0, 1'b1, PORT_HL_DATA, 8'h00);
    bus_cycle(1'b0, 1'b1, PORT_HL_STATUS, 8'h00);
    tape_rate = 10;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    void'($urandom(32'hdb3e_6798));
    RESET_n = 1'b0;
    cpu_addr_i = '0;
    cpu_data_i = '0;
    cpu_mreq_n_i = 1'b1;
    cpu_iorq_n_i = 1'b1;
    cpu_rd_n_i = 1'b1;
    cpu_wr_n_i = 1'b1;
    rom_data_i = '0;
    sram_data_i = '0;
    kb_rows_i = '1;
    ear_i = 1'b0;
    tape_data_i = '0;
    tape_valid_i = 1'b0;
    tape_rate = 10;
    test_name = "reset";
    apply_reset();
    test_name = "random";
    repeat (RAND_TX) random_transaction(1'b0);
    test_name = "fifo fill 1";
    fill_and_drain();
    test_name = "random with lock";
    repeat (RAND_TX) random_transaction(1'b1);
    test_name = "fifo fill 2";
    fill_and_drain();
    test_name = "lock after reset";
    // make sure the lock is set before reset
    bus_cycle(1'b0, 1'b0, PORT_7FFD, 8'h3f);
    bus_cycle(1'b0, 1'b1, PORT_7FFD, 8'h00);
    // lock must be open again after reset
    apply_reset();
    bus_cycle(1'b0, 1'b1, PORT_7FFD, 8'h00);
    bus_cycle(1'b0, 1'b0, PORT_7FFD, 8'h17);
    bus_cycle(1'b0, 1'b1, PORT_7FFD, 8'h00);
    bus_cycle(1'b1, 1'b1, 16'hc123, 8'h00);
    bus_cycle(1'b1, 1'b1, 16'h0123, 8'h00);
    test_name = "interrupt";
    repeat (2 * INT_PERIOD) idle_cycle();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== bench/zx128_glue_assert.sv ====
module hyperload_fifo_assert
  import zx128_pkg::*;
(
  input logic               clk14m,
  input logic               RESET_n,
  input logic               tape_ready_o,
  input logic               empty_o,
  input logic               pop_i,
  input logic [FIFO_AW-1:0] wr_ptr_i,
  input logic [FIFO_AW-1:0] rd_ptr_i,
  input logic [FIFO_AW:0]   count_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // a refused byte leaves the occupancy alone
  refused_push_holds_count: assert property (@(posedge clk14m) disable iff (!RESET_n)
    !tape_ready_o && !pop_i |=> count_i == $past(count_i))
    else $error("fifo occupancy changed while tape_ready_o was low");

  occupancy_in_range: assert property (@(posedge clk14m) disable iff (!RESET_n)
    count_i <= FIFO_DEPTH) else $error("fifo occupancy above depth");

  // decode gates the pop with empty
  no_pop_when_empty: assert property (@(posedge clk14m) disable iff (!RESET_n)
    empty_o |-> !pop_i) else $error("fifo popped while empty");

  // pointers and count move together
  ptrs_track_count: assert property (@(posedge clk14m) disable iff (!RESET_n)
    (wr_ptr_i - rd_ptr_i) == count_i[FIFO_AW-1:0])
    else $error("fifo pointers disagree with occupancy");

endmodule

bind hyperload_fifo hyperload_fifo_assert u_fifo_assert (
  .clk14m(clk14m), .RESET_n(RESET_n), .tape_ready_o(tape_ready_o), .empty_o(empty_o),
  .pop_i(pop_i), .wr_ptr_i(wr_ptr), .rd_ptr_i(rd_ptr), .count_i(count)
);

// ==== src/cpu_bus_decode.sv ====
module cpu_bus_decode
  import zx128_pkg::*;
(
  input  logic [ADDR_W-1:0] cpu_addr_i,
  input  logic              cpu_mreq_n_i,
  input  logic              cpu_iorq_n_i,
  input  logic              cpu_rd_n_i,
  input  logic              cpu_wr_n_i,
  input  logic [DATA_W-1:0] rom_data_i,
  input  logic [DATA_W-1:0] sram_data_i,
  input  logic [DATA_W-1:0] kb_data_i,
  input  page_cfg_t         page_cfg_i,
  input  logic [DATA_W-1:0] fifo_data_i,
  input  logic              fifo_empty_i,
  input  logic              fifo_full_i,
  output logic              fe_wr_o,
  output logic              p7ffd_wr_o,
  output logic              hreq_wr_o,
  output logic              ram_wr_o,
  output logic              hl_pop_o,
  output logic [DATA_W-1:0] cpu_data_o
);

  logic mem_rd;
  logic mem_wr;
  logic io_rd;
  logic io_wr;
  logic rom_area;
  logic hl_data_rd;
  logic hl_status_rd;
  logic fe_rd;
  logic p7ffd_rd;
  logic [DATA_W-1:0] hl_status;

  ////////////////////////////////////////
  // cycle type
  ////////////////////////////////////////
  assign mem_rd = !cpu_mreq_n_i && !cpu_rd_n_i;
  assign mem_wr = !cpu_mreq_n_i && !cpu_wr_n_i;
  assign io_rd = !cpu_iorq_n_i && !cpu_rd_n_i;
  assign io_wr = !cpu_iorq_n_i && !cpu_wr_n_i;

  // bottom 16k is rom
  assign rom_area = (cpu_addr_i[15:14] == 2'b00);

  // write selects
  assign fe_wr_o = io_wr && !cpu_addr_i[0];
  assign p7ffd_wr_o = io_wr && (cpu_addr_i == PORT_7FFD);
  assign hreq_wr_o = io_wr && (cpu_addr_i == PORT_HL_STATUS);
  assign ram_wr_o = mem_wr && !rom_area;

  // read selects
  assign hl_data_rd = io_rd && (cpu_addr_i == PORT_HL_DATA);
  assign hl_status_rd = io_rd && (cpu_addr_i == PORT_HL_STATUS);
  assign fe_rd = io_rd && (cpu_addr_i[7:0] == PORT_FE_LO);
  assign p7ffd_rd = io_rd && (cpu_addr_i == PORT_7FFD);

  // an empty fifo is never popped
  assign hl_pop_o = hl_data_rd && !fifo_empty_i;

  assign hl_status = {6'b000000, fifo_full_i, fifo_empty_i};

  ////////////////////////////////////////
  // read data mux, first match wins
  ////////////////////////////////////////
  always_comb begin
    if (hl_data_rd) begin
      cpu_data_o = fifo_empty_i ? 8'hff : fifo_data_i;
    end else if (hl_status_rd) begin
      cpu_data_o = hl_status;
    end else if (mem_rd) begin
      cpu_data_o = rom_area ? rom_data_i : sram_data_i;
    end else if (fe_rd) begin
      cpu_data_o = kb_data_i;
    end else if (p7ffd_rd) begin
      cpu_data_o = {2'b00, page_cfg_i};
    end else begin
      // floating bus
      cpu_data_o = 8'hff;
    end
  end

endmodule

// ==== src/frame_interrupt.sv ====
module frame_interrupt
  import zx128_pkg::*;
(
  input  logic clk14m,
  input  logic RESET_n,
  output logic int_o
);

  logic [$clog2(INT_PERIOD)-1:0] cnt;
  logic [$clog2(INT_PERIOD)-1:0] cnt_next;

  // wraps after INT_PERIOD-1
  assign cnt_next = (cnt == INT_PERIOD - 1) ? '0 : cnt + 1'b1;

  // int_o registered off the next count so it lines up with cnt
  always_ff @(posedge clk14m) begin
    if (!RESET_n) begin
      cnt <= '0;
      int_o <= 1'b0;
    end else begin
      cnt <= cnt_next;
      int_o <= (cnt_next >= 1) && (cnt_next <= INT_ON);
    end
  end

endmodule

// ==== src/hyperload_fifo.sv ====
module hyperload_fifo
  import zx128_pkg::*;
(
  input  logic              clk14m,
  input  logic              RESET_n,
  input  logic [DATA_W-1:0] tape_data_i,
  input  logic              tape_valid_i,
  input  logic              pop_i,
  output logic              tape_ready_o,
  output logic [DATA_W-1:0] data_o,
  output logic              empty_o,
  output logic              full_o
);

  logic [DATA_W-1:0] mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0] count;
  logic push;
  logic pop;

  ////////////////////////////////////////
  // flags and handshake
  ////////////////////////////////////////
  assign empty_o = (count == '0);
  assign full_o = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign tape_ready_o = !full_o;
  assign push = tape_valid_i && tape_ready_o;
  assign pop = pop_i && !empty_o;

  // show-ahead, head byte always on data_o
  assign data_o = mem[rd_ptr];

  always_ff @(posedge clk14m) begin
    if (push) begin
      mem[wr_ptr] <= tape_data_i;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk14m) begin
    if (!RESET_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      unique case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/io_regs.sv ====
module io_regs
  import zx128_pkg::*;
(
  input  logic              clk14m,
  input  logic              RESET_n,
  input  logic [DATA_W-1:0] cpu_data_i,
  input  logic              fe_wr_i,
  input  logic              p7ffd_wr_i,
  input  logic              hreq_wr_i,
  output logic [2:0]        border_o,
  output logic              mic_o,
  output logic              ear_o,
  output logic              tape_hreq_o,
  output page_cfg_t         page_cfg_o
);

  ////////////////////////////////////////
  // port fe outputs
  ////////////////////////////////////////
  always_ff @(posedge clk14m) begin
    if (!RESET_n) begin
      border_o <= 3'b000;
      mic_o <= 1'b0;
      ear_o <= 1'b0;
    end else if (fe_wr_i) begin
      border_o <= cpu_data_i[2:0];
      mic_o <= cpu_data_i[3];
      ear_o <= cpu_data_i[4];
    end
  end

  ////////////////////////////////////////
  // 128 paging
  ////////////////////////////////////////
  always_ff @(posedge clk14m) begin
    if (!RESET_n) begin
      page_cfg_o <= '0;
    end else if (p7ffd_wr_i && !page_cfg_o.lock) begin
      // once locked only reset reopens it
      page_cfg_o <= page_cfg_t'(cpu_data_i[5:0]);
    end
  end

  // tape request to the loader side
  always_ff @(posedge clk14m) begin
    if (!RESET_n) begin
      tape_hreq_o <= 1'b0;
    end else if (hreq_wr_i) begin
      tape_hreq_o <= cpu_data_i[0];
    end
  end

endmodule

// ==== src/keyboard_port.sv ====
module keyboard_port
  import zx128_pkg::*;
(
  input  logic [KB_ROWS-1:0]         row_sel_i,
  input  logic [KB_ROWS*KB_COLS-1:0] kb_rows_i,
  input  logic                       ear_i,
  output logic [DATA_W-1:0]          kb_data_o
);

  logic [KB_COLS-1:0] keys;

  // keys are active low, a 0 in the high byte selects a half-row
  always_comb begin
    keys = '1;
    for (int r = 0; r < KB_ROWS; r++) begin
      if (!row_sel_i[r]) begin
        keys = keys & kb_rows_i[r*KB_COLS +: KB_COLS];
      end
    end
  end

  // bits 7 and 5 always read high
  assign kb_data_o = {1'b1, ear_i, 1'b1, keys};

endmodule

// ==== src/mem_mapper.sv ====
module mem_mapper
  import zx128_pkg::*;
(
  input  logic [ADDR_W-1:0]  cpu_addr_i,
  input  page_cfg_t          page_cfg_i,
  input  logic               ram_wr_i,
  output logic [ROM_AW-1:0]  rom_addr_o,
  output logic [SRAM_AW-1:0] sram_addr_o,
  output logic               sram_we_o
);

  bank_t bank;

  // bank per 16k quarter
  always_comb begin
    unique case (cpu_addr_i[15:14])
      2'b01: bank = BANK_AT_4000;
      2'b10: bank = BANK_AT_8000;
      2'b11: bank = {1'b0, page_cfg_i.ram_page};
      // rom quarter, sram not used here
      default: bank = '0;
    endcase
  end

  // two roms of 16k each
  assign rom_addr_o = {page_cfg_i.rom_sel, cpu_addr_i[13:0]};

  assign sram_addr_o = {1'b0, bank, cpu_addr_i[13:0]};

  // ram_wr already excludes the rom area
  assign sram_we_o = ram_wr_i;

endmodule

// ==== src/zx128_glue.sv ====
module zx128_glue
  import zx128_pkg::*;
(
  input  logic                       clk14m,
  input  logic                       RESET_n,
  input  logic [ADDR_W-1:0]          cpu_addr_i,
  input  logic [DATA_W-1:0]          cpu_data_i,
  input  logic                       cpu_mreq_n_i,
  input  logic                       cpu_iorq_n_i,
  input  logic                       cpu_rd_n_i,
  input  logic                       cpu_wr_n_i,
  input  logic [DATA_W-1:0]          rom_data_i,
  input  logic [DATA_W-1:0]          sram_data_i,
  input  logic [KB_ROWS*KB_COLS-1:0] kb_rows_i,
  input  logic                       ear_i,
  input  logic [DATA_W-1:0]          tape_data_i,
  input  logic                       tape_valid_i,
  output logic [DATA_W-1:0]          cpu_data_o,
  output logic [ROM_AW-1:0]          rom_addr_o,
  output logic [SRAM_AW-1:0]         sram_addr_o,
  output logic [DATA_W-1:0]          sram_data_o,
  output logic                       sram_we_o,
  output logic [2:0]                 border_o,
  output logic                       mic_o,
  output logic                       ear_o,
  output logic                       tape_hreq_o,
  output logic                       tape_ready_o,
  output logic                       int_o
);

  logic fe_wr;
  logic p7ffd_wr;
  logic hreq_wr;
  logic ram_wr;
  logic hl_pop;
  logic [DATA_W-1:0] kb_data;
  logic [DATA_W-1:0] fifo_data;
  logic fifo_empty;
  logic fifo_full;
  page_cfg_t page_cfg;

  // sram write data comes straight off the cpu bus
  assign sram_data_o = cpu_data_i;

  cpu_bus_decode u_decode (
    .cpu_addr_i(cpu_addr_i), .cpu_mreq_n_i(cpu_mreq_n_i), .cpu_iorq_n_i(cpu_iorq_n_i),
    .cpu_rd_n_i(cpu_rd_n_i), .cpu_wr_n_i(cpu_wr_n_i), .rom_data_i(rom_data_i),
    .sram_data_i(sram_data_i), .kb_data_i(kb_data), .page_cfg_i(page_cfg),
    .fifo_data_i(fifo_data), .fifo_empty_i(fifo_empty), .fifo_full_i(fifo_full),
    .fe_wr_o(fe_wr), .p7ffd_wr_o(p7ffd_wr), .hreq_wr_o(hreq_wr), .ram_wr_o(ram_wr),
    .hl_pop_o(hl_pop), .cpu_data_o(cpu_data_o)
  );

  io_regs u_io_regs (
    .clk14m(clk14m), .RESET_n(RESET_n), .cpu_data_i(cpu_data_i), .fe_wr_i(fe_wr),
    .p7ffd_wr_i(p7ffd_wr), .hreq_wr_i(hreq_wr), .border_o(border_o), .mic_o(mic_o),
    .ear_o(ear_o), .tape_hreq_o(tape_hreq_o), .page_cfg_o(page_cfg)
  );

  mem_mapper u_mem_mapper (
    .cpu_addr_i(cpu_addr_i), .page_cfg_i(page_cfg), .ram_wr_i(ram_wr),
    .rom_addr_o(rom_addr_o), .sram_addr_o(sram_addr_o), .sram_we_o(sram_we_o)
  );

  // high address byte picks the half-rows
  keyboard_port u_keyboard (
    .row_sel_i(cpu_addr_i[15:8]), .kb_rows_i(kb_rows_i), .ear_i(ear_i), .kb_data_o(kb_data)
  );

  frame_interrupt u_frame_int (
    .clk14m(clk14m), .RESET_n(RESET_n), .int_o(int_o)
  );

  hyperload_fifo u_hl_fifo (
    .clk14m(clk14m), .RESET_n(RESET_n), .tape_data_i(tape_data_i),
    .tape_valid_i(tape_valid_i), .pop_i(hl_pop), .tape_ready_o(tape_ready_o),
    .data_o(fifo_data), .empty_o(fifo_empty), .full_o(fifo_full)
  );

endmodule

// ==== src/zx128_pkg.sv ====
package zx128_pkg;

  ////////////////////////////////////////
  // bus and memory widths
  ////////////////////////////////////////
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;
  localparam int SRAM_AW = 19;
  localparam int ROM_AW = 15;

  // keyboard matrix, 8 half-rows of 5 keys
  localparam int KB_ROWS = 8;
  localparam int KB_COLS = 5;

  ////////////////////////////////////////
  // io ports
  ////////////////////////////////////////
  localparam logic [7:0] PORT_FE_LO = 8'hfe;
  localparam logic [ADDR_W-1:0] PORT_7FFD = 16'h7ffd;
  localparam logic [ADDR_W-1:0] PORT_HL_DATA = 16'h0dff;
  localparam logic [ADDR_W-1:0] PORT_HL_STATUS = 16'h0eff;

  // 16k sram bank number
  typedef logic [3:0] bank_t;

  // fixed banks behind 4000 and 8000
  localparam bank_t BANK_AT_4000 = 4'd5;
  localparam bank_t BANK_AT_8000 = 4'd2;

  // hyperload fifo
  localparam int FIFO_DEPTH = 512;
  localparam int FIFO_AW = 9;

  // frame interrupt, 50 Hz at 14 MHz
  localparam int INT_PERIOD = 280000;
  localparam int INT_ON = 256;

  // 7ffd register contents, same bit order as the port
  typedef struct packed {
    logic lock;
    logic rom_sel;
    logic shadow;
    logic [2:0] ram_page;
  } page_cfg_t;

endpackage

// ==== zx128_glue.f ====
src/zx128_pkg.sv
src/cpu_bus_decode.sv
src/io_regs.sv
src/mem_mapper.sv
src/keyboard_port.sv
src/frame_interrupt.sv
src/hyperload_fifo.sv
src/zx128_glue.sv
bench/zx128_glue_assert.sv
bench/tb_zx128_glue.sv
